// ==== hw/core_types_pkg.sv ====
`default_nettype none

package core_types_pkg;

    // machine sizes
    localparam int ARCH_REG_SZ = 8;
    localparam int PHYS_REG_SZ = 16;
    localparam int ROB_SZ      = 16;
    localparam int CDB_WIDTH   = 2;

    // free-list head counts 0..ROB_SZ, hence the extra bit
    localparam int FL_HEAD_W  = $clog2(ROB_SZ + 1);
    localparam int ROB_TAIL_W = $clog2(ROB_SZ);

    typedef logic [$clog2(ARCH_REG_SZ)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] phys_idx_t;
    typedef logic [FL_HEAD_W-1:0]           fl_head_t;
    typedef logic [ROB_TAIL_W-1:0]          rob_tail_t;

    typedef struct packed {
        phys_idx_t reg_idx;
        logic      ready;
    } map_entry_t;

    typedef struct packed {
        logic      valid;
        logic      is_branch;
        logic      writes_dest;
        arch_idx_t dest_reg;
        phys_idx_t new_preg;
        fl_head_t  fl_head;
        rob_tail_t rob_tail;
    } dispatch_packet_t;

    // one completion broadcast
    typedef struct packed {
        logic      valid;
        arch_idx_t reg_idx;
        phys_idx_t p_reg_idx;
    } cdb_packet_t;

endpackage

`default_nettype wire

// ==== hw/branch_pkg.sv ====
`default_nettype none

package branch_pkg;

    import core_types_pkg::*;

    localparam int BRANCH_DEPTH = 4;

    // one-hot id, or a set of ids when used as a mask
    typedef logic [BRANCH_DEPTH-1:0] branch_mask_t;

    typedef enum logic [1:0] {
        NONE   = 2'd0,
        CLEAR  = 2'd1,
        SQUASH = 2'd2
    } br_task_t;

    typedef struct packed {
        logic                               valid;
        branch_mask_t                       b_id;
        branch_mask_t                       b_mask;
        map_entry_t [ARCH_REG_SZ-1:0]       rec_map;
        fl_head_t                           fl_head;
        rob_tail_t                          rob_tail;
    } checkpoint_t;

    typedef struct packed {
        logic      valid;
        fl_head_t  fl_head;
        rob_tail_t rob_tail;
    } recovery_packet_t;

    typedef struct packed {
        logic         valid;
        branch_mask_t b_id;
        logic         mispredicted;
    } resolve_packet_t;

endpackage

`default_nettype wire

// ==== hw/lowest_free_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module lowest_free_select
    import branch_pkg::*;
(
    input  branch_mask_t req,
    output branch_mask_t gnt
);

    logic found;

    // scan from slot 0 upward, first set bit wins
    always_comb begin
        gnt   = '0;
        found = 1'b0;
        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (req[i] && !found) begin
                gnt[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/branch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_decode
    import core_types_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  dispatch_packet_t dispatch,
    input  logic             full,
    input  logic             squashing,
    output dispatch_packet_t dis_branch,
    output dispatch_packet_t dis_rename,
    output logic             dispatch_stall
);

    logic accept;

    // nothing gets through while the map is being restored
    assign accept = dispatch.valid && !squashing;

    always_comb begin
        dis_branch       = dispatch;
        dis_branch.valid = accept && dispatch.is_branch && !full;

        // branches carry no destination, so only plain writers rename
        dis_rename       = dispatch;
        dis_rename.valid = accept && !dispatch.is_branch && dispatch.writes_dest;
    end

    assign dispatch_stall = squashing || (dispatch.valid && dispatch.is_branch && full);

    // a squash always frees at least its own checkpoint
    squash_frees_slot: assert property (
        @(posedge clock) disable iff (reset)
        squashing |=> !full
    ) else $error("checkpoint stack still full after a squash");

endmodule

`default_nettype wire

// ==== hw/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
    import branch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  resolve_packet_t resolve,
    output br_task_t        br_task,
    output branch_mask_t    rem_b_id,
    output logic            squashing
);

    // command lives for exactly one cycle after the resolution
    always_ff @(posedge clock) begin
        if (reset) begin
            br_task <= NONE;
        end else if (resolve.valid) begin
            br_task <= resolve.mispredicted ? SQUASH : CLEAR;
        end else begin
            br_task <= NONE;
        end
    end

    always_ff @(posedge clock) begin
        rem_b_id <= resolve.b_id;
    end

    assign squashing = (br_task == SQUASH);

    // execute must name exactly one branch
    command_is_one_hot: assert property (
        @(posedge clock) disable iff (reset)
        (br_task != NONE) |-> $onehot(rem_b_id)
    ) else $error("branch command does not name exactly one branch");

endmodule

`default_nettype wire

// ==== hw/branch_checkpoint_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_checkpoint_stack
    import core_types_pkg::*, branch_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  dispatch_packet_t             dis_branch,
    input  map_entry_t [ARCH_REG_SZ-1:0] cur_map,
    input  cdb_packet_t [CDB_WIDTH-1:0]  cdb,
    input  br_task_t                     br_task,
    input  branch_mask_t                 rem_b_id,
    output branch_mask_t                 assigned_b_id,
    output checkpoint_t                  cp_out,
    output logic                         full
);

    checkpoint_t [BRANCH_DEPTH-1:0] entries;
    checkpoint_t [BRANCH_DEPTH-1:0] next_entries;

    // one bit per slot, set when the slot is free
    branch_mask_t free_entries;
    branch_mask_t next_free_entries;
    branch_mask_t stack_gnt;
    branch_mask_t live_ids;
    logic         cmd_hit;

    lowest_free_select slot_select (
        .req(free_entries),
        .gnt(stack_gnt)
    );

    assign full = (free_entries == '0);

    always_comb begin
        next_entries      = entries;
        next_free_entries = free_entries;
        cp_out            = '0;
        cmd_hit           = 1'b0;
        live_ids          = '0;
        assigned_b_id     = '0;

        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (entries[i].valid && entries[i].b_id == rem_b_id && br_task != NONE) begin
                cmd_hit = 1'b1;
            end
        end

        // squash drops the branch and everything that depends on it
        if (br_task == SQUASH) begin
            for (int i = 0; i < BRANCH_DEPTH; i++) begin
                if (entries[i].valid && entries[i].b_id == rem_b_id) begin
                    cp_out = entries[i];
                end
                if (entries[i].valid && (entries[i].b_mask & rem_b_id) != '0) begin
                    next_entries[i].valid = 1'b0;
                    next_free_entries[i]  = 1'b1;
                end
            end
        end

        // clear retires the id and strips it from younger masks
        if (br_task == CLEAR) begin
            for (int i = 0; i < BRANCH_DEPTH; i++) begin
                if (entries[i].valid && entries[i].b_id == rem_b_id) begin
                    next_entries[i].valid = 1'b0;
                    next_free_entries[i]  = 1'b1;
                end else if (entries[i].valid) begin
                    next_entries[i].b_mask = entries[i].b_mask & ~rem_b_id;
                end
            end
        end

        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (next_entries[i].valid) begin
                live_ids = live_ids | next_entries[i].b_id;
            end
        end

        // new checkpoint goes into the lowest free slot
        if (dis_branch.valid) begin
            for (int k = 0; k < BRANCH_DEPTH; k++) begin
                if (stack_gnt[k]) begin
                    next_entries[k].valid    = 1'b1;
                    next_entries[k].b_id     = stack_gnt;
                    next_entries[k].b_mask   = live_ids | stack_gnt;
                    next_entries[k].rec_map  = cur_map;
                    next_entries[k].fl_head  = dis_branch.fl_head;
                    next_entries[k].rob_tail = dis_branch.rob_tail;
                    next_free_entries[k]     = 1'b0;
                end
            end
            assigned_b_id = stack_gnt;
        end

        // completions also wake up saved maps
        for (int i = 0; i < CDB_WIDTH; i++) begin
            for (int j = 0; j < BRANCH_DEPTH; j++) begin
                if (cdb[i].valid && next_entries[j].valid &&
                    next_entries[j].rec_map[cdb[i].reg_idx].reg_idx == cdb[i].p_reg_idx) begin
                    next_entries[j].rec_map[cdb[i].reg_idx].ready = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_entries <= '1;
            for (int i = 0; i < BRANCH_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            free_entries <= next_free_entries;
            entries      <= next_entries;
        end
    end

    // resolve must only name branches this stack handed out
    command_names_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        (br_task != NONE) |-> cmd_hit
    ) else $error("branch command names no live checkpoint");

endmodule

`default_nettype wire

// ==== hw/rename_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_map_table
    import core_types_pkg::*, branch_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  dispatch_packet_t             dis_rename,
    input  cdb_packet_t [CDB_WIDTH-1:0]  cdb,
    input  checkpoint_t                  restore,
    input  arch_idx_t                    lookup_reg,
    output map_entry_t                   lookup_entry,
    output map_entry_t [ARCH_REG_SZ-1:0] cur_map
);

    map_entry_t [ARCH_REG_SZ-1:0] map;
    map_entry_t [ARCH_REG_SZ-1:0] next_map;

    always_comb begin
        // a squash replaces the whole speculative map
        next_map = restore.valid ? restore.rec_map : map;

        for (int i = 0; i < CDB_WIDTH; i++) begin
            if (cdb[i].valid && next_map[cdb[i].reg_idx].reg_idx == cdb[i].p_reg_idx) begin
                next_map[cdb[i].reg_idx].ready = 1'b1;
            end
        end

        // fresh destination waits for its producer
        if (dis_rename.valid) begin
            next_map[dis_rename.dest_reg].reg_idx = dis_rename.new_preg;
            next_map[dis_rename.dest_reg].ready   = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping, all values committed
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                map[i].reg_idx <= phys_idx_t'(i);
                map[i].ready   <= 1'b1;
            end
        end else begin
            map <= next_map;
        end
    end

    assign lookup_entry = map[lookup_reg];
    assign cur_map      = map;

endmodule

`default_nettype wire

// ==== hw/branch_recovery_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_recovery_top
    import core_types_pkg::*, branch_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  dispatch_packet_t            dispatch,
    input  cdb_packet_t [CDB_WIDTH-1:0] cdb,
    input  resolve_packet_t             resolve,
    input  arch_idx_t                   lookup_reg,
    output branch_mask_t                assigned_b_id,
    output logic                        full,
    output recovery_packet_t            recovery,
    output map_entry_t                  lookup_entry,
    output logic                        dispatch_stall
);

    dispatch_packet_t             dis_branch;
    dispatch_packet_t             dis_rename;
    br_task_t                     br_task;
    branch_mask_t                 rem_b_id;
    logic                         squashing;
    checkpoint_t                  cp_out;
    map_entry_t [ARCH_REG_SZ-1:0] cur_map;

    branch_decode decode_inst (
        .clock(clock),
        .reset(reset),
        .dispatch(dispatch),
        .full(full),
        .squashing(squashing),
        .dis_branch(dis_branch),
        .dis_rename(dis_rename),
        .dispatch_stall(dispatch_stall)
    );

    branch_resolve resolve_inst (
        .clock(clock),
        .reset(reset),
        .resolve(resolve),
        .br_task(br_task),
        .rem_b_id(rem_b_id),
        .squashing(squashing)
    );

    branch_checkpoint_stack stack_inst (
        .clock(clock),
        .reset(reset),
        .dis_branch(dis_branch),
        .cur_map(cur_map),
        .cdb(cdb),
        .br_task(br_task),
        .rem_b_id(rem_b_id),
        .assigned_b_id(assigned_b_id),
        .cp_out(cp_out),
        .full(full)
    );

    rename_map_table map_inst (
        .clock(clock),
        .reset(reset),
        .dis_rename(dis_rename),
        .cdb(cdb),
        .restore(cp_out),
        .lookup_reg(lookup_reg),
        .lookup_entry(lookup_entry),
        .cur_map(cur_map)
    );

    // free list and ROB rewind from the returned checkpoint
    assign recovery.valid    = cp_out.valid;
    assign recovery.fl_head  = cp_out.fl_head;
    assign recovery.rob_tail = cp_out.rob_tail;

endmodule

`default_nettype wire

// ==== tb/branch_recovery_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_recovery_tb
    import core_types_pkg::*, branch_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_STEPS = 60;

    // one cycle of stimulus plus the outputs the model predicts for it
    typedef struct packed {
        dispatch_packet_t            dis;
        cdb_packet_t [CDB_WIDTH-1:0] cdb;
        resolve_packet_t             res;
        arch_idx_t                   lookup;
        branch_mask_t                exp_b_id;
        logic                        exp_full;
        logic                        exp_stall;
        recovery_packet_t            exp_rec;
        map_entry_t                  exp_lookup;
    } step_t;

    logic                        clock;
    logic                        reset;
    dispatch_packet_t            dispatch;
    cdb_packet_t [CDB_WIDTH-1:0] cdb;
    resolve_packet_t             resolve;
    arch_idx_t                   lookup_reg;
    branch_mask_t                assigned_b_id;
    logic                        full;
    recovery_packet_t            recovery;
    map_entry_t                  lookup_entry;
    logic                        dispatch_stall;

    // reference model state
    map_entry_t [ARCH_REG_SZ-1:0] ref_map;
    checkpoint_t                  ref_cp [BRANCH_DEPTH];
    br_task_t                     ref_task;
    branch_mask_t                 ref_task_id;

    step_t            steps[$];
    int               error_count;
    logic             table_ready;
    dispatch_packet_t no_dis;
    cdb_packet_t      no_cdb;
    resolve_packet_t  no_res;

    branch_recovery_top branch_recovery_top_inst (
        .clock(clock),
        .reset(reset),
        .dispatch(dispatch),
        .cdb(cdb),
        .resolve(resolve),
        .lookup_reg(lookup_reg),
        .assigned_b_id(assigned_b_id),
        .full(full),
        .recovery(recovery),
        .lookup_entry(lookup_entry),
        .dispatch_stall(dispatch_stall)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic dispatch_packet_t branch_op(fl_head_t fl, rob_tail_t rob);
        dispatch_packet_t d;
        d           = '0;
        d.valid     = 1'b1;
        d.is_branch = 1'b1;
        d.fl_head   = fl;
        d.rob_tail  = rob;
        return d;
    endfunction

    function automatic dispatch_packet_t rename_op(arch_idx_t dest, phys_idx_t preg);
        dispatch_packet_t d;
        d             = '0;
        d.valid       = 1'b1;
        d.writes_dest = 1'b1;
        d.dest_reg    = dest;
        d.new_preg    = preg;
        return d;
    endfunction

    function automatic resolve_packet_t resolution(branch_mask_t id, logic misp);
        resolve_packet_t r;
        r.valid        = 1'b1;
        r.b_id         = id;
        r.mispredicted = misp;
        return r;
    endfunction

    function automatic cdb_packet_t broadcast(arch_idx_t a, phys_idx_t p);
        cdb_packet_t c;
        c.valid     = 1'b1;
        c.reg_idx   = a;
        c.p_reg_idx = p;
        return c;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < ARCH_REG_SZ; i++) begin
            ref_map[i].reg_idx = phys_idx_t'(i);
            ref_map[i].ready   = 1'b1;
        end
        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            ref_cp[i] = '0;
        end
        ref_task    = NONE;
        ref_task_id = '0;
    endtask

    // predict this cycle's outputs, then move the model across the clock edge
    task automatic apply_cycle(inout step_t s);
        map_entry_t [ARCH_REG_SZ-1:0] nmap;
        checkpoint_t                  ncp [BRANCH_DEPTH];
        logic                         squashing;
        logic                         is_full;
        int                           slot;
        branch_mask_t                 live;
        squashing = (ref_task == SQUASH);
        is_full   = 1'b1;
        slot      = -1;
        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (!ref_cp[i].valid) begin
                is_full = 1'b0;
                if (slot < 0) slot = i;
            end
        end
        s.exp_full   = is_full;
        s.exp_stall  = squashing || (s.dis.valid && s.dis.is_branch && is_full);
        s.exp_lookup = ref_map[s.lookup];
        s.exp_rec    = '0;
        s.exp_b_id   = '0;
        nmap         = ref_map;
        ncp          = ref_cp;

        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (ref_cp[i].valid && ref_task != NONE) begin
                if (ref_cp[i].b_id == ref_task_id) begin
                    ncp[i].valid = 1'b0;
                    if (squashing) begin
                        s.exp_rec.valid    = 1'b1;
                        s.exp_rec.fl_head  = ref_cp[i].fl_head;
                        s.exp_rec.rob_tail = ref_cp[i].rob_tail;
                        nmap               = ref_cp[i].rec_map;
                    end
                end else if (squashing) begin
                    // younger branches carry the squashed id in their mask
                    if ((ref_cp[i].b_mask & ref_task_id) != '0) ncp[i].valid = 1'b0;
                end else begin
                    ncp[i].b_mask = ref_cp[i].b_mask & ~ref_task_id;
                end
            end
        end

        if (s.dis.valid && s.dis.is_branch && !is_full && !squashing) begin
            live = '0;
            for (int i = 0; i < BRANCH_DEPTH; i++) begin
                if (ncp[i].valid) live = live | ncp[i].b_id;
            end
            s.exp_b_id            = branch_mask_t'(1 << slot);
            ncp[slot].valid       = 1'b1;
            ncp[slot].b_id        = s.exp_b_id;
            ncp[slot].b_mask      = live | s.exp_b_id;
            ncp[slot].rec_map     = ref_map;
            ncp[slot].fl_head     = s.dis.fl_head;
            ncp[slot].rob_tail    = s.dis.rob_tail;
        end

        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (s.cdb[c].valid) begin
                if (nmap[s.cdb[c].reg_idx].reg_idx == s.cdb[c].p_reg_idx) begin
                    nmap[s.cdb[c].reg_idx].ready = 1'b1;
                end
                for (int i = 0; i < BRANCH_DEPTH; i++) begin
                    if (ncp[i].valid &&
                        ncp[i].rec_map[s.cdb[c].reg_idx].reg_idx == s.cdb[c].p_reg_idx) begin
                        ncp[i].rec_map[s.cdb[c].reg_idx].ready = 1'b1;
                    end
                end
            end
        end

        if (s.dis.valid && !s.dis.is_branch && s.dis.writes_dest && !squashing) begin
            nmap[s.dis.dest_reg].reg_idx = s.dis.new_preg;
            nmap[s.dis.dest_reg].ready   = 1'b0;
        end
        ref_map = nmap;
        ref_cp  = ncp;
    endtask

    // resolution becomes next cycle's command
    task automatic latch_resolve(step_t s);
        if (!s.res.valid) ref_task = NONE;
        else if (s.res.mispredicted) ref_task = SQUASH;
        else ref_task = CLEAR;
        ref_task_id = s.res.b_id;
    endtask

    task automatic push_step(dispatch_packet_t d, cdb_packet_t c0, cdb_packet_t c1,
                             resolve_packet_t r, arch_idx_t look);
        step_t s;
        s        = '0;
        s.dis    = d;
        s.cdb[0] = c0;
        s.cdb[1] = c1;
        s.res    = r;
        s.lookup = look;
        apply_cycle(s);
        latch_resolve(s);
        steps.push_back(s);
    endtask

    task automatic random_step();
        step_t        s;
        int           kind;
        int           pick;
        arch_idx_t    a;
        branch_mask_t live[$];
        s    = '0;
        kind = $urandom_range(0, 3);
        if (kind == 1) begin
            s.dis = branch_op(fl_head_t'($urandom_range(0, ROB_SZ)), rob_tail_t'($urandom));
        end else if (kind >= 2) begin
            s.dis             = rename_op(arch_idx_t'($urandom), phys_idx_t'($urandom));
            s.dis.writes_dest = ($urandom_range(0, 7) != 0);
        end
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if ($urandom_range(0, 1) == 1) begin
                a = arch_idx_t'($urandom);
                // mostly hit the live mapping so ready bits actually change
                if ($urandom_range(0, 3) != 0) s.cdb[c] = broadcast(a, ref_map[a].reg_idx);
                else s.cdb[c] = broadcast(a, phys_idx_t'($urandom));
            end
        end
        s.lookup = arch_idx_t'($urandom);
        apply_cycle(s);
        // only name branches still alive when the command executes
        for (int i = 0; i < BRANCH_DEPTH; i++) begin
            if (ref_cp[i].valid) live.push_back(ref_cp[i].b_id);
        end
        if (live.size() > 0 && $urandom_range(0, 2) == 0) begin
            pick  = $urandom_range(0, live.size() - 1);
            s.res = resolution(live[pick], $urandom_range(0, 1) == 1);
        end
        latch_resolve(s);
        steps.push_back(s);
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    initial begin
        wait (table_ready);
        #((steps.size() + 20) * CLK_PERIOD);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout, the step table did not finish in time");
    end

    initial begin
        void'($urandom(32'h3fe38f8a));
        error_count = 0;
        table_ready = 1'b0;
        reset       = 1'b1;
        dispatch    = '0;
        cdb         = '0;
        resolve     = '0;
        lookup_reg  = '0;
        no_dis      = '0;
        no_cdb      = '0;
        no_res      = '0;
        reset_model();

        // fill all four checkpoints, then a fifth branch while full
        push_step(rename_op(3'd1, 4'd8), no_cdb, no_cdb, no_res, 3'd1);
        push_step(branch_op(5'd3, 4'd2), no_cdb, no_cdb, no_res, 3'd1);
        push_step(rename_op(3'd2, 4'd9), no_cdb, no_cdb, no_res, 3'd2);
        push_step(branch_op(5'd5, 4'd4), no_cdb, no_cdb, no_res, 3'd2);
        push_step(rename_op(3'd3, 4'd10), no_cdb, no_cdb, no_res, 3'd3);
        push_step(branch_op(5'd7, 4'd6), no_cdb, no_cdb, no_res, 3'd3);
        push_step(branch_op(5'd8, 4'd7), no_cdb, no_cdb, no_res, 3'd1);
        push_step(branch_op(5'd9, 4'd8), broadcast(3'd1, 4'd8), no_cdb, no_res, 3'd1);
        // clear the oldest, its id is reused
        push_step(no_dis, no_cdb, no_cdb, resolution(4'b0001, 1'b0), 3'd1);
        push_step(no_dis, no_cdb, no_cdb, no_res, 3'd1);
        push_step(branch_op(5'd10, 4'd9), no_cdb, no_cdb, no_res, 3'd4);
        push_step(rename_op(3'd4, 4'd11), no_cdb, no_cdb, no_res, 3'd4);
        // squash a younger branch, dispatch in the squash cycle is dropped
        push_step(rename_op(3'd5, 4'd12), no_cdb, no_cdb, resolution(4'b0100, 1'b1), 3'd5);
        push_step(rename_op(3'd1, 4'd13), broadcast(3'd3, 4'd10), no_cdb, no_res, 3'd1);
        push_step(no_dis, no_cdb, no_cdb, no_res, 3'd1);
        push_step(no_dis, no_cdb, no_cdb, no_res, 3'd3);
        push_step(branch_op(5'd11, 4'd12), no_cdb, no_cdb, no_res, 3'd4);
        push_step(branch_op(5'd12, 4'd13), no_cdb, no_cdb, no_res, 3'd5);
        push_step(branch_op(5'd13, 4'd14), no_cdb, no_cdb, no_res, 3'd2);
        push_step(branch_op(5'd14, 4'd15), no_cdb, no_cdb, no_res, 3'd0);
        push_step(no_dis, no_cdb, no_cdb, resolution(4'b0010, 1'b0), 3'd2);
        push_step(no_dis, no_cdb, no_cdb, no_res, 3'd6);
        repeat (RANDOM_STEPS) random_step();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        foreach (steps[k]) begin
            dispatch   = steps[k].dis;
            cdb        = steps[k].cdb;
            resolve    = steps[k].res;
            lookup_reg = steps[k].lookup;
            #1;
            compare("assigned_b_id", 32'(assigned_b_id), 32'(steps[k].exp_b_id));
            compare("full", 32'(full), 32'(steps[k].exp_full));
            compare("dispatch_stall", 32'(dispatch_stall), 32'(steps[k].exp_stall));
            compare("recovery", 32'(recovery), 32'(steps[k].exp_rec));
            compare("lookup_entry", 32'(lookup_entry), 32'(steps[k].exp_lookup));
            @(negedge clock);
        end
        dispatch = '0;
        cdb      = '0;
        resolve  = '0;

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "%0d output mismatches", error_count);
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/core_types_pkg.sv
hw/branch_pkg.sv
hw/lowest_free_select.sv
hw/branch_decode.sv
hw/branch_resolve.sv
hw/branch_checkpoint_stack.sv
hw/rename_map_table.sv
hw/branch_recovery_top.sv
tb/branch_recovery_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= branch_recovery_tb
RTL_TOP   ?= branch_recovery_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
